//--- filelist.f
source/cd_ctrl_pkg.sv
source/cd_order_fifo.sv
source/cd_lane.sv
source/cd_forward.sv
source/cd_ctrl.sv
verification/cd_ctrl_props.sv
verification/tb_cd_ctrl.sv

//--- verification/tb_cd_ctrl.sv
// Random testbench for the CD collection path.
// Pushes orders and beat streams, checks ready, stall and delivery against a model.

`timescale 1ns/1ps

module tb_cd_ctrl;

    localparam int unsigned NumPorts   = cd_ctrl_pkg::NumSnoopPorts;
    localparam int unsigned FifoDepth  = 4;
    localparam int unsigned NumOrders  = 200;
    localparam int unsigned MaxBeats   = 4;
    localparam int unsigned CycleLimit = NumOrders * MaxBeats * 8 + 500;
    localparam int unsigned Seed       = 63426;

    logic                                      clk_i;
    logic                                      rst_ni;
    logic                                      order_push_i;
    cd_ctrl_pkg::cd_order_t                    order_i;
    logic                                      order_stall_o;
    cd_ctrl_pkg::cd_beat_t [NumPorts-1:0]      cd_i;
    logic [NumPorts-1:0]                       cd_valid_i;
    logic [NumPorts-1:0]                       cd_ready_o;
    logic                                      mu_full_i;
    logic                                      su_full_i;
    cd_ctrl_pkg::cd_beat_t                     mu_cd_o;
    logic                                      mu_cd_valid_o;
    cd_ctrl_pkg::cd_beat_t                     su_cd_o;
    logic                                      su_cd_valid_o;

    // Model state
    cd_ctrl_pkg::cd_order_t orders_q [$];
    cd_ctrl_pkg::cd_beat_t  port_q [NumPorts][$];
    cd_ctrl_pkg::cd_beat_t  mu_exp_q [$];
    cd_ctrl_pkg::cd_beat_t  su_exp_q [$];
    logic [NumPorts-1:0]    seen_last;
    int unsigned            stored_cnt;
    int unsigned            pushed_cnt;
    int unsigned            err_cnt;
    int unsigned            cycle_cnt = 0;

    // Inputs for the next cycle
    logic                                 nxt_push;
    cd_ctrl_pkg::cd_order_t               nxt_order;
    logic [NumPorts-1:0]                  nxt_valid;
    cd_ctrl_pkg::cd_beat_t [NumPorts-1:0] nxt_beats;
    logic                                 nxt_mu_full;
    logic                                 nxt_su_full;

    cd_ctrl #(
        .FifoDepth (FifoDepth)
    ) cd_ctrl_i (
        .clk_i,
        .rst_ni,
        .order_push_i,
        .order_i,
        .order_stall_o,
        .cd_i,
        .cd_valid_i,
        .cd_ready_o,
        .mu_full_i,
        .su_full_i,
        .mu_cd_o,
        .mu_cd_valid_o,
        .su_cd_o,
        .su_cd_valid_o
    );

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CycleLimit) begin
            $display("Run exceeded %0d cycles with %0d orders pending", CycleLimit,
                     orders_q.size());
            $display("TB FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // Model helpers
    ////////////////////////////////////////////////////////////////////////

    task automatic report_value(input string name, input logic [127:0] exp_val,
                                input logic [127:0] obs_val);
        err_cnt++;
        $display("ERR %s expected %0h observed %0h at %0t", name, exp_val, obs_val, $time);
    endtask

    function automatic cd_ctrl_pkg::cd_order_t random_order();
        cd_ctrl_pkg::cd_order_t ord;
        ord.dest = $urandom_range(1) ? cd_ctrl_pkg::SNOOP_UNIT : cd_ctrl_pkg::MEMORY_UNIT;
        ord.first_responder = cd_ctrl_pkg::PortIdxWidth'($urandom_range(NumPorts - 1));
        ord.data_avail = NumPorts'($urandom);
        ord.data_avail[ord.first_responder] = 1'b1;
        return ord;
    endfunction

    // Beat streams for every masked port, first responder's also to its destination
    task automatic queue_beats(input cd_ctrl_pkg::cd_order_t ord);
        cd_ctrl_pkg::cd_beat_t beat;
        int                    n;
        for (int i = 0; i < NumPorts; i++) begin
            if (ord.data_avail[i]) begin
                n = $urandom_range(MaxBeats, 1);
                for (int b = 0; b < n; b++) begin
                    beat.data = {$urandom, $urandom};
                    beat.last = (b == n - 1);
                    port_q[i].push_back(beat);
                    if (i == int'(ord.first_responder)) begin
                        if (ord.dest == cd_ctrl_pkg::MEMORY_UNIT) begin
                            mu_exp_q.push_back(beat);
                        end else begin
                            su_exp_q.push_back(beat);
                        end
                    end
                end
            end
        end
    endtask

    function automatic logic [NumPorts-1:0] expected_ready();
        logic [NumPorts-1:0]    ready;
        cd_ctrl_pkg::cd_order_t head;
        logic                   full;
        ready = '0;
        if (orders_q.size() > 0) begin
            head  = orders_q[0];
            full  = (head.dest == cd_ctrl_pkg::MEMORY_UNIT) ? mu_full_i : su_full_i;
            ready = head.data_avail & ~seen_last;
            if (full) begin
                ready[head.first_responder] = 1'b0;
            end
        end
        return ready;
    endfunction

    task automatic check_delivery(input logic to_memory, input logic valid_obs,
                                  input logic valid_exp, input cd_ctrl_pkg::cd_beat_t beat_obs);
        cd_ctrl_pkg::cd_beat_t beat_exp;
        if (valid_obs !== valid_exp) begin
            report_value(to_memory ? "mu_cd_valid_o" : "su_cd_valid_o", valid_exp, valid_obs);
        end
        if (valid_obs === 1'b1) begin
            if ((to_memory && mu_exp_q.size() == 0) || (!to_memory && su_exp_q.size() == 0)) begin
                err_cnt++;
                $display("Beat delivered to the %s while none was expected there",
                         to_memory ? "memory unit" : "snoop unit");
            end else begin
                if (to_memory) begin
                    beat_exp = mu_exp_q.pop_front();
                end else begin
                    beat_exp = su_exp_q.pop_front();
                end
                if (beat_obs !== beat_exp) begin
                    report_value(to_memory ? "mu_cd_o" : "su_cd_o", beat_exp, beat_obs);
                end
            end
        end
    endtask

    // Compare this cycle, then move the model past the coming edge
    task automatic check_and_advance();
        logic [NumPorts-1:0]    exp_ready;
        logic [NumPorts-1:0]    xfer;
        logic                   exp_stall;
        logic                   retire;
        logic                   fr_xfer;
        cd_ctrl_pkg::cd_order_t head;
        exp_ready = expected_ready();
        exp_stall = (stored_cnt == FifoDepth);
        xfer      = cd_valid_i & exp_ready;
        head      = (orders_q.size() > 0) ? orders_q[0] : '0;
        retire    = (orders_q.size() > 0) && (seen_last == head.data_avail);
        fr_xfer   = xfer[head.first_responder];
        if (cd_ready_o !== exp_ready) begin
            report_value("cd_ready_o", exp_ready, cd_ready_o);
        end
        if (order_stall_o !== exp_stall) begin
            report_value("order_stall_o", exp_stall, order_stall_o);
        end
        check_delivery(1'b1, mu_cd_valid_o,
                       fr_xfer && head.dest == cd_ctrl_pkg::MEMORY_UNIT, mu_cd_o);
        check_delivery(1'b0, su_cd_valid_o,
                       fr_xfer && head.dest == cd_ctrl_pkg::SNOOP_UNIT, su_cd_o);
        for (int i = 0; i < NumPorts; i++) begin
            if (xfer[i] && port_q[i].size() > 0) begin
                if (port_q[i][0].last) begin
                    seen_last[i] = 1'b1;
                end
                void'(port_q[i].pop_front());
            end
        end
        if (retire) begin
            void'(orders_q.pop_front());
            seen_last = '0;
        end
        stored_cnt = stored_cnt + int'(order_push_i) - int'(retire);
    endtask

    task automatic plan_inputs();
        nxt_push  = (pushed_cnt < NumOrders) && (stored_cnt < FifoDepth)
                    && ($urandom_range(3) != 0);
        nxt_order = '0;
        if (nxt_push) begin
            nxt_order = random_order();
            orders_q.push_back(nxt_order);
            queue_beats(nxt_order);
            pushed_cnt++;
        end
        for (int i = 0; i < NumPorts; i++) begin
            nxt_valid[i] = (port_q[i].size() > 0) && ($urandom_range(3) != 0);
            nxt_beats[i] = (port_q[i].size() > 0) ? port_q[i][0] : '0;
        end
        // Long full stretches, toggled rarely
        nxt_mu_full = mu_full_i ? ($urandom_range(11) != 0) : ($urandom_range(31) == 0);
        nxt_su_full = su_full_i ? ($urandom_range(11) != 0) : ($urandom_range(31) == 0);
    endtask

    ////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////

    initial begin
        rst_ni       = 1'b0;
        order_push_i = 1'b0;
        order_i      = '0;
        cd_i         = '0;
        cd_valid_i   = '0;
        mu_full_i    = 1'b0;
        su_full_i    = 1'b0;
        seen_last    = '0;
        stored_cnt   = 0;
        pushed_cnt   = 0;
        err_cnt      = 0;
        void'($urandom(Seed));

        repeat (5) @(posedge clk_i);
        rst_ni <= 1'b1;

        while (pushed_cnt < NumOrders || orders_q.size() > 0) begin
            @(negedge clk_i);
            check_and_advance();
            plan_inputs();
            @(posedge clk_i);
            order_push_i <= nxt_push;
            order_i      <= nxt_order;
            cd_valid_i   <= nxt_valid;
            cd_i         <= nxt_beats;
            mu_full_i    <= nxt_mu_full;
            su_full_i    <= nxt_su_full;
        end
        repeat (4) @(posedge clk_i);

        for (int i = 0; i < NumPorts; i++) begin
            if (port_q[i].size() != 0) begin
                err_cnt++;
                $display("Port %0d still holds %0d undelivered beats", i, port_q[i].size());
            end
        end
        if (mu_exp_q.size() != 0 || su_exp_q.size() != 0) begin
            err_cnt++;
            $display("Destinations missed beats: %0d memory unit, %0d snoop unit",
                     mu_exp_q.size(), su_exp_q.size());
        end

        $display("Errors: %0d model checks, %0d assertion failures", err_cnt,
                 cd_ctrl_i.cd_ctrl_props_i.fail_count);
        if (err_cnt == 0 && cd_ctrl_i.cd_ctrl_props_i.fail_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- verification/cd_ctrl_props.sv
// Concurrent checks on the CD collection path.
// Bound into cd_ctrl for the random testbench.

`timescale 1ns/1ps

module cd_ctrl_props (
    input  logic                                                clk_i,
    input  logic                                                rst_ni,
    input  logic                                                order_push_i,
    input  logic                                                order_stall_i,
    input  cd_ctrl_pkg::cd_order_t                              head_i,
    input  logic                                                fifo_empty_i,
    input  cd_ctrl_pkg::cd_beat_t [cd_ctrl_pkg::NumSnoopPorts-1:0] cd_i,
    input  logic [cd_ctrl_pkg::NumSnoopPorts-1:0]               cd_valid_i,
    input  logic [cd_ctrl_pkg::NumSnoopPorts-1:0]               cd_ready_i,
    input  logic                                                mu_full_i,
    input  logic                                                su_full_i,
    input  cd_ctrl_pkg::cd_beat_t                               mu_cd_i,
    input  cd_ctrl_pkg::cd_beat_t                               su_cd_i,
    input  logic                                                mu_cd_valid_i,
    input  logic                                                su_cd_valid_i
);

    int unsigned fail_count = 0;

    logic                                  pushed_q;
    logic [cd_ctrl_pkg::NumSnoopPorts-1:0] port_done_q;
    logic [cd_ctrl_pkg::NumSnoopPorts-1:0] last_xfer;
    logic                                  retire;
    cd_ctrl_pkg::cd_beat_t                 fr_beat;
    logic                                  fr_xfer;
    logic                                  dest_full;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            pushed_q <= 1'b0;
        end else if (order_push_i) begin
            pushed_q <= 1'b1;
        end
    end

    // Ports that handed over their last beat for the head order
    always_comb begin
        for (int i = 0; i < cd_ctrl_pkg::NumSnoopPorts; i++) begin
            last_xfer[i] = cd_valid_i[i] && cd_ready_i[i] && cd_i[i].last;
        end
    end

    assign retire = !fifo_empty_i && (port_done_q == head_i.data_avail);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            port_done_q <= '0;
        end else if (retire) begin
            port_done_q <= '0;
        end else begin
            port_done_q <= port_done_q | last_xfer;
        end
    end

    assign fr_beat   = cd_i[head_i.first_responder];
    assign fr_xfer   = cd_valid_i[head_i.first_responder] && cd_ready_i[head_i.first_responder];
    assign dest_full = (head_i.dest == cd_ctrl_pkg::MEMORY_UNIT) ? mu_full_i : su_full_i;

    ////////////////////////////////////////////////////////////////////
    // Idle state and destination pulses
    ////////////////////////////////////////////////////////////////////

    idle_before_push: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(pushed_q || order_push_i) |->
            (cd_ready_i == '0 && !mu_cd_valid_i && !su_cd_valid_i && !order_stall_i))
        else begin
            fail_count++;
            $error("Outputs active before the first order was pushed");
        end

    mu_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mu_cd_valid_i |-> (!fifo_empty_i && head_i.dest == cd_ctrl_pkg::MEMORY_UNIT
                           && fr_xfer && mu_cd_i == fr_beat))
        else begin
            fail_count++;
            $error("Memory unit pulse without a matching first responder transfer");
        end

    su_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
        su_cd_valid_i |-> (!fifo_empty_i && head_i.dest == cd_ctrl_pkg::SNOOP_UNIT
                           && fr_xfer && su_cd_i == fr_beat))
        else begin
            fail_count++;
            $error("Snoop unit pulse without a matching first responder transfer");
        end

    ////////////////////////////////////////////////////////////////////
    // Per-port ready rules
    ////////////////////////////////////////////////////////////////////

    for (genvar i = 0; i < cd_ctrl_pkg::NumSnoopPorts; i++) begin : gen_port
        ready_in_mask: assert property (@(posedge clk_i) disable iff (!rst_ni)
            cd_ready_i[i] |-> (!fifo_empty_i && head_i.data_avail[i]))
            else begin
                fail_count++;
                $error("Port %0d ready outside the head mask", i);
            end

        quiet_after_last: assert property (@(posedge clk_i) disable iff (!rst_ni)
            port_done_q[i] |-> !cd_ready_i[i])
            else begin
                fail_count++;
                $error("Port %0d ready again before its order retired", i);
            end

        // Full destination blocks only the first responder
        held_when_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
            (!fifo_empty_i && dest_full && head_i.first_responder == i) |-> !cd_ready_i[i])
            else begin
                fail_count++;
                $error("Port %0d ready while its destination is full", i);
            end

        drains_when_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
            (!fifo_empty_i && dest_full && head_i.first_responder != i
             && head_i.data_avail[i] && !port_done_q[i]) |-> cd_ready_i[i])
            else begin
                fail_count++;
                $error("Port %0d stalled by the full level of another port", i);
            end
    end

endmodule

bind cd_ctrl cd_ctrl_props cd_ctrl_props_i (
    .clk_i,
    .rst_ni,
    .order_push_i,
    .order_stall_i (order_stall_o),
    .head_i        (head),
    .fifo_empty_i  (fifo_empty),
    .cd_i,
    .cd_valid_i,
    .cd_ready_i    (cd_ready_o),
    .mu_full_i,
    .su_full_i,
    .mu_cd_i       (mu_cd_o),
    .su_cd_i       (su_cd_o),
    .mu_cd_valid_i (mu_cd_valid_o),
    .su_cd_valid_i (su_cd_valid_o)
);

//--- source/cd_ctrl.sv
// Snoop-data collection path of the coherence controller.
// Orders enter the FIFO, lanes gather CD beats, the forwarder delivers them.

`timescale 1ns/1ps

module cd_ctrl #(
    parameter int unsigned FifoDepth = 4
) (
    input  logic                                                clk_i,
    input  logic                                                rst_ni,
    input  logic                                                order_push_i,
    input  cd_ctrl_pkg::cd_order_t                              order_i,
    output logic                                                order_stall_o,
    input  cd_ctrl_pkg::cd_beat_t [cd_ctrl_pkg::NumSnoopPorts-1:0] cd_i,
    input  logic [cd_ctrl_pkg::NumSnoopPorts-1:0]               cd_valid_i,
    output logic [cd_ctrl_pkg::NumSnoopPorts-1:0]               cd_ready_o,
    input  logic                                                mu_full_i,
    input  logic                                                su_full_i,
    output cd_ctrl_pkg::cd_beat_t                               mu_cd_o,
    output logic                                                mu_cd_valid_o,
    output cd_ctrl_pkg::cd_beat_t                               su_cd_o,
    output logic                                                su_cd_valid_o
);

    cd_ctrl_pkg::cd_order_t                    head;
    logic                                      fifo_empty;
    logic                                      done;
    logic [cd_ctrl_pkg::NumSnoopPorts-1:0]     hold_lane;
    logic [cd_ctrl_pkg::NumSnoopPorts-1:0]     last_seen;

    ////////////////////////////////////////////////////////////////////
    // Order FIFO
    ////////////////////////////////////////////////////////////////////

    cd_order_fifo #(
        .FifoDepth (FifoDepth)
    ) cd_order_fifo_i (
        .clk_i,
        .rst_ni,
        .push_i   (order_push_i),
        .entry_i  (order_i),
        .pop_i    (done),
        .head_o   (head),
        .empty_o  (fifo_empty),
        .full_o   (order_stall_o)
    );

    ////////////////////////////////////////////////////////////////////
    // Per-port lanes
    ////////////////////////////////////////////////////////////////////

    for (genvar i = 0; i < cd_ctrl_pkg::NumSnoopPorts; i++) begin : gen_lane
        cd_lane cd_lane_i (
            .clk_i,
            .rst_ni,
            .active_i    (!fifo_empty && head.data_avail[i]),
            .hold_i      (hold_lane[i]),
            .done_i      (done),
            .cd_valid_i  (cd_valid_i[i]),
            .cd_last_i   (cd_i[i].last),
            .ready_o     (cd_ready_o[i]),
            .last_seen_o (last_seen[i])
        );
    end

    ////////////////////////////////////////////////////////////////////
    // Forwarding to the destinations
    ////////////////////////////////////////////////////////////////////

    cd_forward cd_forward_i (
        .head_i        (head),
        .empty_i       (fifo_empty),
        .cd_i          (cd_i),
        .cd_valid_i    (cd_valid_i),
        .lane_ready_i  (cd_ready_o),
        .last_seen_i   (last_seen),
        .mu_full_i     (mu_full_i),
        .su_full_i     (su_full_i),
        .hold_lane_o   (hold_lane),
        .done_o        (done),
        .mu_cd_o       (mu_cd_o),
        .su_cd_o       (su_cd_o),
        .mu_cd_valid_o (mu_cd_valid_o),
        .su_cd_valid_o (su_cd_valid_o)
    );

endmodule

//--- source/cd_forward.sv
// Forwards the first responder's CD beats to the destination of the head
// order, applies that destination's back-pressure and detects retirement.

`timescale 1ns/1ps

module cd_forward (
    input  cd_ctrl_pkg::cd_order_t                              head_i,
    input  logic                                                empty_i,
    input  cd_ctrl_pkg::cd_beat_t [cd_ctrl_pkg::NumSnoopPorts-1:0] cd_i,
    input  logic [cd_ctrl_pkg::NumSnoopPorts-1:0]               cd_valid_i,
    input  logic [cd_ctrl_pkg::NumSnoopPorts-1:0]               lane_ready_i,
    input  logic [cd_ctrl_pkg::NumSnoopPorts-1:0]               last_seen_i,
    input  logic                                                mu_full_i,
    input  logic                                                su_full_i,
    output logic [cd_ctrl_pkg::NumSnoopPorts-1:0]               hold_lane_o,
    output logic                                                done_o,
    output cd_ctrl_pkg::cd_beat_t                               mu_cd_o,
    output cd_ctrl_pkg::cd_beat_t                               su_cd_o,
    output logic                                                mu_cd_valid_o,
    output logic                                                su_cd_valid_o
);

    logic [cd_ctrl_pkg::PortIdxWidth-1:0] first_responder;
    cd_ctrl_pkg::cd_beat_t                fr_beat;
    logic                                 fr_handshake;
    logic                                 dest_full;
    logic                                 to_memory;

    ////////////////////////////////////////////////////////////////////
    // First responder
    ////////////////////////////////////////////////////////////////////

    assign first_responder = head_i.first_responder;
    assign to_memory       = (head_i.dest == cd_ctrl_pkg::MEMORY_UNIT);

    assign fr_beat = cd_i[first_responder];

    // Lane ready already carries empty, mask and hold
    assign fr_handshake = cd_valid_i[first_responder] && lane_ready_i[first_responder];

    ////////////////////////////////////////////////////////////////////
    // Destination routing and back-pressure
    ////////////////////////////////////////////////////////////////////

    always_comb begin
        mu_cd_valid_o = 1'b0;
        su_cd_valid_o = 1'b0;
        dest_full     = 1'b0;
        if (!empty_i) begin
            if (to_memory) begin
                mu_cd_valid_o = fr_handshake;
                dest_full     = mu_full_i;
            end else begin
                su_cd_valid_o = fr_handshake;
                dest_full     = su_full_i;
            end
        end
    end

    // Payload is shared, the valids select the consumer
    assign mu_cd_o = fr_beat;
    assign su_cd_o = fr_beat;

    // Only the first responder waits on a full destination
    always_comb begin
        hold_lane_o = '0;
        for (int i = 0; i < cd_ctrl_pkg::NumSnoopPorts; i++) begin
            if (first_responder == cd_ctrl_pkg::PortIdxWidth'(i)) begin
                hold_lane_o[i] = !empty_i && dest_full;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Retirement
    ////////////////////////////////////////////////////////////////////

    // Every masked port has returned its last beat
    assign done_o = !empty_i && (last_seen_i == head_i.data_avail);

endmodule

//--- source/cd_lane.sv
// One snoop port of the CD collector.
// Tracks the last beat of the current order and drives the port's ready.

`timescale 1ns/1ps

module cd_lane (
    input  logic clk_i,
    input  logic rst_ni,
    input  logic active_i,
    input  logic hold_i,
    input  logic done_i,
    input  logic cd_valid_i,
    input  logic cd_last_i,
    output logic ready_o,
    output logic last_seen_o
);

    logic last_seen_q;
    logic accept;

    // Port drains until its last beat, unless the destination holds it
    assign ready_o = active_i && !hold_i && !last_seen_q;
    assign accept  = cd_valid_i && ready_o;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            last_seen_q <= 1'b0;
        end else if (done_i) begin
            last_seen_q <= 1'b0;
        end else if (accept && cd_last_i) begin
            last_seen_q <= 1'b1;
        end
    end

    assign last_seen_o = last_seen_q;

endmodule

//--- source/cd_order_fifo.sv
// Ordering FIFO of pending CD orders, fall-through on an empty buffer.
// The head is the order whose data is being collected.

`timescale 1ns/1ps

module cd_order_fifo #(
    parameter int unsigned FifoDepth = 4
) (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   push_i,
    input  cd_ctrl_pkg::cd_order_t entry_i,
    input  logic                   pop_i,
    output cd_ctrl_pkg::cd_order_t head_o,
    output logic                   empty_o,
    output logic                   full_o
);

    localparam int unsigned PtrWidth   = (FifoDepth > 1) ? $clog2(FifoDepth) : 1;
    localparam int unsigned CountWidth = $clog2(FifoDepth + 1);

    localparam logic [PtrWidth-1:0]   LastPtr   = PtrWidth'(FifoDepth - 1);
    localparam logic [CountWidth-1:0] FullCount = CountWidth'(FifoDepth);

    cd_ctrl_pkg::cd_order_t mem_q [FifoDepth];

    logic [PtrWidth-1:0]   rd_ptr_q;
    logic [PtrWidth-1:0]   wr_ptr_q;
    logic [CountWidth-1:0] usage_q;
    logic [CountWidth-1:0] usage_d;

    logic stored_empty;
    logic do_push;
    logic do_pop;
    logic bypass;
    logic write_en;
    logic read_en;

    assign stored_empty = (usage_q == '0);
    assign full_o       = (usage_q == FullCount);

    // A push into an empty buffer is visible at once
    assign empty_o = stored_empty && !push_i;
    assign head_o  = stored_empty ? entry_i : mem_q[rd_ptr_q];

    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;

    // Entry passes straight through and is never stored
    assign bypass   = do_push && do_pop && stored_empty;
    assign write_en = do_push && !bypass;
    assign read_en  = do_pop && !bypass;

    assign usage_d = usage_q + CountWidth'(write_en) - CountWidth'(read_en);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            usage_q  <= '0;
        end else begin
            usage_q <= usage_d;
            if (write_en) begin
                wr_ptr_q <= (wr_ptr_q == LastPtr) ? '0 : wr_ptr_q + 1'b1;
            end
            if (read_en) begin
                rd_ptr_q <= (rd_ptr_q == LastPtr) ? '0 : rd_ptr_q + 1'b1;
            end
        end
    end

    // Storage
    always_ff @(posedge clk_i) begin
        if (write_en) begin
            mem_q[wr_ptr_q] <= entry_i;
        end
    end

endmodule

//--- source/cd_ctrl_pkg.sv
// Shared types and sizes of the snoop-data collection path.
// The RTL refers to these by scoped names.

package cd_ctrl_pkg;

    ////////////////////////////////////////////////////////////////////
    // Sizes
    ////////////////////////////////////////////////////////////////////

    // Snoop ports that can return data
    localparam int unsigned NumSnoopPorts = 4;

    localparam int unsigned PortIdxWidth =
        (NumSnoopPorts > 1) ? $clog2(NumSnoopPorts) : 1;

    // Data bits carried by one CD beat
    localparam int unsigned CdDataWidth = 64;

    ////////////////////////////////////////////////////////////////////
    // Types
    ////////////////////////////////////////////////////////////////////

    // Consumer of the collected data
    typedef enum logic {
        MEMORY_UNIT = 1'b0,
        SNOOP_UNIT  = 1'b1
    } cd_dest_e;

    // One pending write-back or snoop read
    typedef struct packed {
        cd_dest_e                  dest;
        logic [PortIdxWidth-1:0]   first_responder;
        logic [NumSnoopPorts-1:0]  data_avail;
    } cd_order_t;

    // One CD beat as seen on a snoop port
    typedef struct packed {
        logic [CdDataWidth-1:0] data;
        logic                   last;
    } cd_beat_t;

endpackage
